/* hw/avr_defines.svh */
// Width macros for the AVR subset core
// SREG bit positions of the kept flags
`ifndef AVR_DEFINES_SVH
`define AVR_DEFINES_SVH

// Instruction word and register sizes
`define INSTR_WIDTH 16
`define DATA_WIDTH  8

// 1024 words of program space
`define PC_WIDTH    10

// 32 general purpose registers
`define RADDR_WIDTH 5

// SREG layout with bits 7..4 never set
`define FLAG_C 0
`define FLAG_Z 1
`define FLAG_N 2
`define FLAG_V 3

`endif

/* hw/avr_pkg.sv */
// Shared types of the AVR subset core
// Decoded operation, FSM state and the instruction word union
package avr_pkg;

    // Decoded operation
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_ADC,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_EOR,
        OP_MOV,
        OP_LDI,
        OP_SUBI,
        OP_ANDI,
        OP_ORI,
        OP_INC,
        OP_DEC,
        OP_NEG,
        OP_RJMP,
        OP_BRBS,    // Branch if SREG bit set
        OP_BRBC     // Branch if SREG bit cleared
    } avr_op_e;

    // One state per cycle of an instruction
    typedef enum logic [1:0] {
        ST_IF,
        ST_ID,
        ST_EX,
        ST_WB
    } cpu_state_e;

    // The same 16 bits seen as register form or as immediate form
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic       rr_hi;   // Rr bit 4
            logic [4:0] rd;
            logic [3:0] rr_lo;   // Rr bits 3..0
        } reg_fmt;
        struct packed {
            logic [3:0] opcode;
            logic [3:0] k_hi;
            logic [3:0] rd;      // Selects r16..r31
            logic [3:0] k_lo;
        } imm_fmt;
    } instr_word_u;

endpackage

/* hw/instr_decoder.sv */
// Instruction decoder for the AVR subset
// Opcode match, register fields, immediate and branch offset
`include "avr_defines.svh"

module instr_decoder import avr_pkg::*; (
    input  logic [`INSTR_WIDTH-1:0] instr_buf,
    output avr_op_e                 op,
    output logic [`RADDR_WIDTH-1:0] rd_addr,
    output logic [`RADDR_WIDTH-1:0] rr_addr,
    output logic [`DATA_WIDTH-1:0]  imm,
    output logic                    use_imm,
    output logic [2:0]              branch_bit,
    output logic [11:0]             branch_offset
);

    instr_word_u word;

    assign word = instr_buf;

    always_comb begin
        op = OP_NOP;
        // 4-bit opcodes never overlap the 6-bit ones below
        case (word.imm_fmt.opcode)
            4'b1110: op = OP_LDI;
            4'b0101: op = OP_SUBI;
            4'b0111: op = OP_ANDI;
            4'b0110: op = OP_ORI;
            4'b1100: op = OP_RJMP;
            default: begin
                case (word.reg_fmt.opcode)
                    6'b000011: op = OP_ADD;
                    6'b000111: op = OP_ADC;
                    6'b000110: op = OP_SUB;
                    6'b001000: op = OP_AND;
                    6'b001001: op = OP_EOR;
                    6'b001010: op = OP_OR;
                    6'b001011: op = OP_MOV;
                    6'b100101: begin
                        // One-operand group needs bit 9 clear
                        if (!word.reg_fmt.rr_hi) begin
                            case (word.reg_fmt.rr_lo)
                                4'b0011: op = OP_INC;
                                4'b1010: op = OP_DEC;
                                4'b0001: op = OP_NEG;
                                default: op = OP_NOP;
                            endcase
                        end
                    end
                    6'b111100: op = OP_BRBS;
                    6'b111101: op = OP_BRBC;
                    default:   op = OP_NOP;
                endcase
            end
        endcase
    end

    assign use_imm = op inside {OP_LDI, OP_SUBI, OP_ANDI, OP_ORI};

    // Immediate forms only reach the upper half of the file
    assign rd_addr = use_imm ? {1'b1, word.imm_fmt.rd} : word.reg_fmt.rd;
    assign rr_addr = {word.reg_fmt.rr_hi, word.reg_fmt.rr_lo};
    assign imm     = {word.imm_fmt.k_hi, word.imm_fmt.k_lo};

    assign branch_bit = instr_buf[2:0];   // SREG bit for BRBS/BRBC

    // 12-bit RJMP offset as is, 7-bit branch offset sign-extended
    assign branch_offset = (op == OP_RJMP) ? instr_buf[11:0] :
                           {{5{instr_buf[9]}}, instr_buf[9:3]};

endmodule

/* hw/alu_execute.sv */
// ALU of the AVR subset core
// 8-bit result and next C, Z, N, V flags
`include "avr_defines.svh"

module alu_execute import avr_pkg::*; (
    input  avr_op_e                op,
    input  logic [`DATA_WIDTH-1:0] opnd_a,
    input  logic [`DATA_WIDTH-1:0] opnd_b,
    input  logic                   carry_in,
    output logic [`DATA_WIDTH-1:0] alu_result,
    output logic [`DATA_WIDTH-1:0] alu_flags
);

    localparam int MSB = `DATA_WIDTH - 1;

    logic [`DATA_WIDTH:0]   sum;     // Top bit is carry out
    logic [`DATA_WIDTH:0]   diff;    // Top bit is borrow
    logic [`DATA_WIDTH-1:0] sub_a;
    logic [`DATA_WIDTH-1:0] sub_b;
    logic                   adc_cin;
    logic                   add_v;
    logic                   sub_v;
    logic                   c_out;
    logic                   v_out;

    assign adc_cin = (op == OP_ADC) && carry_in;

    // NEG runs as 0 - Rd on the subtractor
    assign sub_a = (op == OP_NEG) ? '0 : opnd_a;
    assign sub_b = (op == OP_NEG) ? opnd_a : opnd_b;

    assign sum  = {1'b0, opnd_a} + {1'b0, opnd_b} + {{`DATA_WIDTH{1'b0}}, adc_cin};
    assign diff = {1'b0, sub_a} - {1'b0, sub_b};

    // Two's complement overflow
    assign add_v = (opnd_a[MSB] & opnd_b[MSB] & ~sum[MSB]) |
                   (~opnd_a[MSB] & ~opnd_b[MSB] & sum[MSB]);
    assign sub_v = (sub_a[MSB] & ~sub_b[MSB] & ~diff[MSB]) |
                   (~sub_a[MSB] & sub_b[MSB] & diff[MSB]);

    always_comb begin
        alu_result = opnd_a;
        c_out      = carry_in;   // Kept unless the op says otherwise
        v_out      = 1'b0;
        case (op)
            OP_ADD, OP_ADC: begin
                alu_result = sum[MSB:0];
                c_out      = sum[`DATA_WIDTH];
                v_out      = add_v;
            end
            OP_SUB, OP_SUBI, OP_NEG: begin
                alu_result = diff[MSB:0];
                c_out      = diff[`DATA_WIDTH];
                v_out      = sub_v;
            end
            OP_INC: begin
                alu_result = sum[MSB:0];
                v_out      = add_v;
            end
            OP_DEC: begin
                alu_result = diff[MSB:0];
                v_out      = sub_v;
            end
            OP_AND, OP_ANDI: alu_result = opnd_a & opnd_b;
            OP_OR, OP_ORI:   alu_result = opnd_a | opnd_b;
            OP_EOR:          alu_result = opnd_a ^ opnd_b;
            OP_MOV, OP_LDI:  alu_result = opnd_b;   // Source or constant
            default:         alu_result = opnd_a;
        endcase
    end

    always_comb begin
        alu_flags          = '0;
        alu_flags[`FLAG_C] = c_out;
        alu_flags[`FLAG_Z] = (alu_result == '0);
        alu_flags[`FLAG_N] = alu_result[MSB];
        alu_flags[`FLAG_V] = v_out;
    end

endmodule

/* hw/result_unit.sv */
// Register file and status register
// Two asynchronous read ports, one write port
`include "avr_defines.svh"

module result_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`RADDR_WIDTH-1:0] rd_addr,
    input  logic [`RADDR_WIDTH-1:0] rr_addr,
    output logic [`DATA_WIDTH-1:0]  rd_value,
    output logic [`DATA_WIDTH-1:0]  rr_value,
    input  logic                    wb_en,
    input  logic [`RADDR_WIDTH-1:0] wb_addr,
    input  logic [`DATA_WIDTH-1:0]  wb_data,
    input  logic                    flags_we,
    input  logic [`DATA_WIDTH-1:0]  new_flags,
    output logic [`DATA_WIDTH-1:0]  sreg
);

    localparam int NUM_REGS = 2 ** `RADDR_WIDTH;

    logic [`DATA_WIDTH-1:0] regs [NUM_REGS];

    assign rd_value = regs[rd_addr];
    assign rr_value = regs[rr_addr];

    // r0..r31 start at zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Flags arrive already merged by the ALU
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sreg <= '0;
        end else if (flags_we) begin
            sreg <= new_flags;
        end
    end

endmodule

/* hw/control_unit.sv */
// Control unit with the four-state FSM, program counter and branch resolution
// Instruction, operand and ALU output buffers, writeback strobes
`include "avr_defines.svh"

module control_unit import avr_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`INSTR_WIDTH-1:0] instruction,
    output logic [`PC_WIDTH-1:0]    pc,
    output cpu_state_e              state,
    output logic [`INSTR_WIDTH-1:0] instr_buf,
    input  avr_op_e                 op,
    input  logic [`RADDR_WIDTH-1:0] rd_addr,
    input  logic [`DATA_WIDTH-1:0]  imm,
    input  logic                    use_imm,
    input  logic [2:0]              branch_bit,
    input  logic [11:0]             branch_offset,
    input  logic [`DATA_WIDTH-1:0]  rd_value,
    input  logic [`DATA_WIDTH-1:0]  rr_value,
    input  logic [`DATA_WIDTH-1:0]  sreg,
    input  logic [`DATA_WIDTH-1:0]  alu_result,
    input  logic [`DATA_WIDTH-1:0]  alu_flags,
    output logic [`DATA_WIDTH-1:0]  opnd_a,
    output logic [`DATA_WIDTH-1:0]  opnd_b,
    output logic                    wb_en,
    output logic [`RADDR_WIDTH-1:0] wb_addr,
    output logic [`DATA_WIDTH-1:0]  wb_data,
    output logic                    flags_we,
    output logic [`DATA_WIDTH-1:0]  new_flags
);

    logic                 writes_reg;
    logic                 writes_flags;
    logic                 taken;
    logic [`PC_WIDTH-1:0] pc_step;

    assign writes_reg = op inside {OP_ADD, OP_ADC, OP_SUB, OP_AND, OP_OR, OP_EOR, OP_MOV,
                                   OP_LDI, OP_SUBI, OP_ANDI, OP_ORI, OP_INC, OP_DEC, OP_NEG};
    assign writes_flags = writes_reg && !(op inside {OP_MOV, OP_LDI});

    assign taken = (op == OP_RJMP) ||
                   (op == OP_BRBS && sreg[branch_bit]) ||
                   (op == OP_BRBC && !sreg[branch_bit]);
    assign pc_step = taken ? branch_offset[`PC_WIDTH-1:0] : '0;   // Wraps mod 1024

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IF;
        end else begin
            case (state)
                ST_IF:   state <= ST_ID;
                ST_ID:   state <= ST_EX;
                ST_EX:   state <= ST_WB;
                default: state <= ST_IF;
            endcase
        end
    end

    // Next pc takes effect as writeback ends
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (state == ST_WB) begin
            pc <= pc + pc_step + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_buf <= '0;   // Decodes as NOP
        end else if (state == ST_IF) begin
            instr_buf <= instruction;
        end
    end

    // INC and DEC run on the adder with a constant 1
    always_ff @(posedge clk) begin
        if (state == ST_ID) begin
            opnd_a <= rd_value;
            if (op == OP_INC || op == OP_DEC) begin
                opnd_b <= 8'd1;
            end else begin
                opnd_b <= use_imm ? imm : rr_value;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_en    <= 1'b0;
            flags_we <= 1'b0;
        end else begin
            wb_en    <= (state == ST_EX) && writes_reg;   // High for ST_WB only
            flags_we <= (state == ST_EX) && writes_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_EX) begin
            wb_addr   <= rd_addr;
            wb_data   <= alu_result;
            new_flags <= alu_flags;
        end
    end

endmodule

/* hw/avr_core.sv */
// Top level of the multicycle AVR subset core
// Control, decode, execute and result blocks
`include "avr_defines.svh"

module avr_core import avr_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    output logic [`PC_WIDTH-1:0]    pc,
    input  logic [`INSTR_WIDTH-1:0] instruction,
    output logic                    wb_en,
    output logic [`RADDR_WIDTH-1:0] wb_addr,
    output logic [`DATA_WIDTH-1:0]  wb_data,
    output logic [`DATA_WIDTH-1:0]  sreg
);

    avr_op_e                 op;
    logic [`INSTR_WIDTH-1:0] instr_buf;
    logic [`RADDR_WIDTH-1:0] rd_addr;
    logic [`RADDR_WIDTH-1:0] rr_addr;
    logic [`DATA_WIDTH-1:0]  imm;
    logic                    use_imm;
    logic [2:0]              branch_bit;
    logic [11:0]             branch_offset;
    logic [`DATA_WIDTH-1:0]  rd_value;
    logic [`DATA_WIDTH-1:0]  rr_value;
    logic [`DATA_WIDTH-1:0]  opnd_a;
    logic [`DATA_WIDTH-1:0]  opnd_b;
    logic [`DATA_WIDTH-1:0]  alu_result;
    logic [`DATA_WIDTH-1:0]  alu_flags;
    logic                    flags_we;
    logic [`DATA_WIDTH-1:0]  new_flags;

    control_unit u_control (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .pc            (pc),
        .state         (),
        .instr_buf     (instr_buf),
        .op            (op),
        .rd_addr       (rd_addr),
        .imm           (imm),
        .use_imm       (use_imm),
        .branch_bit    (branch_bit),
        .branch_offset (branch_offset),
        .rd_value      (rd_value),
        .rr_value      (rr_value),
        .sreg          (sreg),
        .alu_result    (alu_result),
        .alu_flags     (alu_flags),
        .opnd_a        (opnd_a),
        .opnd_b        (opnd_b),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .flags_we      (flags_we),
        .new_flags     (new_flags)
    );

    instr_decoder u_decoder (
        .instr_buf     (instr_buf),
        .op            (op),
        .rd_addr       (rd_addr),
        .rr_addr       (rr_addr),
        .imm           (imm),
        .use_imm       (use_imm),
        .branch_bit    (branch_bit),
        .branch_offset (branch_offset)
    );

    // Carry for ADC straight from the status register
    alu_execute u_alu (
        .op         (op),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .carry_in   (sreg[`FLAG_C]),
        .alu_result (alu_result),
        .alu_flags  (alu_flags)
    );

    result_unit u_result (
        .clk       (clk),
        .reset     (reset),
        .rd_addr   (rd_addr),
        .rr_addr   (rr_addr),
        .rd_value  (rd_value),
        .rr_value  (rr_value),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .flags_we  (flags_we),
        .new_flags (new_flags),
        .sreg      (sreg)
    );

endmodule

/* tb/tb_avr_core.sv */
// Testbench for the AVR subset core
// Random program ROM, instruction-level reference model, per-instruction checks
`include "avr_defines.svh"

module tb_avr_core import avr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR  = 2000;
    localparam int WB_TIMEOUT = 8;   // Cycles allowed before wb_en must show
    localparam int ROM_WORDS  = 2 ** `PC_WIDTH;

    logic                    clk;
    logic                    reset;
    logic [`PC_WIDTH-1:0]    pc;
    logic [`INSTR_WIDTH-1:0] instruction;
    logic                    wb_en;
    logic [`RADDR_WIDTH-1:0] wb_addr;
    logic [`DATA_WIDTH-1:0]  wb_data;
    logic [`DATA_WIDTH-1:0]  sreg;

    logic [`INSTR_WIDTH-1:0] rom [ROM_WORDS];
    logic [`DATA_WIDTH-1:0]  model_regs [32];
    logic [`DATA_WIDTH-1:0]  model_sreg;
    logic [`PC_WIDTH-1:0]    model_pc;
    integer                  seed;

    avr_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .instruction (instruction),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .sreg        (sreg)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("[ERROR] %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // One clock, then the ROM word at the current pc
    task automatic next_cycle();
        @(posedge clk);
        #5;
        instruction = rom[pc];
    endtask

    // Mostly supported opcodes and only forward jumps so the program keeps moving
    function automatic logic [15:0] random_word();
        logic [31:0] r;
        logic [3:0]  one_op;
        logic [15:0] word;
        r = $random(seed);
        case (r[9:8])
            2'd1:    one_op = 4'b1010;   // DEC
            2'd2:    one_op = 4'b0001;   // NEG
            default: one_op = 4'b0011;   // INC
        endcase
        case (r[19:16])
            4'd0:  word = {4'b1110, r[11:0]};   // LDI
            4'd1:  word = {4'b0101, r[11:0]};   // SUBI
            4'd2:  word = {4'b0111, r[11:0]};   // ANDI
            4'd3:  word = {4'b0110, r[11:0]};   // ORI
            4'd4:  word = {6'b000011, r[9:0]};  // ADD
            4'd5:  word = {6'b000111, r[9:0]};  // ADC
            4'd6:  word = {6'b000110, r[9:0]};  // SUB
            4'd7:  word = {6'b001000, r[9:0]};  // AND
            4'd8:  word = {6'b001010, r[9:0]};  // OR
            4'd9:  word = {6'b001001, r[9:0]};  // EOR
            4'd10: word = {6'b001011, r[9:0]};  // MOV
            4'd11: word = {7'b1001010, r[4:0], one_op};
            4'd12: word = {4'b1100, 7'b0, r[4:0]};
            4'd13: word = {6'b111100, 3'b000, r[7:4], r[2:0]};
            4'd14: word = {6'b111101, 3'b000, r[7:4], r[2:0]};
            default: begin
                // CPI, LDD, CP and LDS groups lie outside the subset
                case (r[13:12])
                    2'd0:    word = {4'b0011, r[11:0]};
                    2'd1:    word = {4'b1000, r[11:0]};
                    2'd2:    word = {6'b000101, r[9:0]};
                    default: word = {6'b100100, r[9:0]};
                endcase
            end
        endcase
        return word;
    endfunction

    // Unsigned sum gives the carry, signed sum the overflow
    function automatic void add8(input logic [7:0] a, input logic [7:0] b, input logic cin,
                                 output logic [7:0] res, output logic c, output logic v);
        int u;
        int s;
        u   = int'(a) + int'(b) + int'(cin);
        s   = int'($signed(a)) + int'($signed(b)) + int'(cin);
        res = u[7:0];
        c   = (u > 255);
        v   = (s > 127) || (s < -128);
    endfunction

    function automatic void sub8(input logic [7:0] a, input logic [7:0] b,
                                 output logic [7:0] res, output logic c, output logic v);
        int u;
        int s;
        u   = int'(a) - int'(b);
        s   = int'($signed(a)) - int'($signed(b));
        res = u[7:0];
        c   = (u < 0);   // Borrow
        v   = (s > 127) || (s < -128);
    endfunction

    // Executes one word on the model state, returns the expected writeback
    task automatic step_model(input logic [15:0] raw, output logic we,
                              output logic [4:0] dst, output logic [7:0] res);
        instr_word_u w;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  k;
        logic        c;
        logic        v;
        int          mode;   // 0 none, 1 CZNV, 2 ZNV, 3 ZN with V cleared
        int          jump;
        w    = raw;
        dst  = w.reg_fmt.rd;
        a    = model_regs[dst];
        b    = model_regs[{w.reg_fmt.rr_hi, w.reg_fmt.rr_lo}];
        k    = {w.imm_fmt.k_hi, w.imm_fmt.k_lo};
        c    = 1'b0;
        v    = 1'b0;
        res  = 8'h00;
        we   = 1'b1;
        mode = 1;
        jump = 1;
        if (w.imm_fmt.opcode inside {4'b1110, 4'b0101, 4'b0111, 4'b0110}) begin
            dst = {1'b1, w.imm_fmt.rd};   // r16..r31
            a   = model_regs[dst];
            mode = (w.imm_fmt.opcode == 4'b0101) ? 1 : 3;
            case (w.imm_fmt.opcode)
                4'b1110: mode = 0;
                4'b0101: sub8(a, k, res, c, v);
                4'b0111: res = a & k;
                default: res = a | k;
            endcase
            if (mode == 0) begin
                res = k;
            end
        end else begin
            case (w.reg_fmt.opcode)
                6'b000011: add8(a, b, 1'b0, res, c, v);
                6'b000111: add8(a, b, model_sreg[`FLAG_C], res, c, v);
                6'b000110: sub8(a, b, res, c, v);
                6'b001000: begin
                    res  = a & b;
                    mode = 3;
                end
                6'b001010: begin
                    res  = a | b;
                    mode = 3;
                end
                6'b001001: begin
                    res  = a ^ b;
                    mode = 3;
                end
                6'b001011: begin
                    res  = b;
                    mode = 0;
                end
                6'b100101: begin
                    mode = 2;
                    case ({w.reg_fmt.rr_hi, w.reg_fmt.rr_lo})
                        5'b00011: add8(a, 8'd1, 1'b0, res, c, v);
                        5'b01010: sub8(a, 8'd1, res, c, v);
                        5'b00001: begin
                            sub8(8'd0, a, res, c, v);
                            mode = 1;
                        end
                        default: begin
                            we   = 1'b0;
                            mode = 0;
                        end
                    endcase
                end
                default: begin
                    we   = 1'b0;
                    mode = 0;
                end
            endcase
        end
        if (w.imm_fmt.opcode == 4'b1100) begin
            jump = 1 + int'($signed(raw[11:0]));
        end
        if ((w.reg_fmt.opcode == 6'b111100 && model_sreg[raw[2:0]]) ||
            (w.reg_fmt.opcode == 6'b111101 && !model_sreg[raw[2:0]])) begin
            jump = 1 + int'($signed(raw[9:3]));
        end
        if (mode != 0) begin
            model_sreg[`FLAG_Z] = (res == 8'h00);
            model_sreg[`FLAG_N] = res[7];
            model_sreg[`FLAG_V] = (mode == 3) ? 1'b0 : v;
            if (mode == 1) begin
                model_sreg[`FLAG_C] = c;
            end
        end
        if (we) begin
            model_regs[dst] = res;
        end
        model_pc = model_pc + jump[9:0];   // Wraps mod 1024
    endtask

    initial begin
        logic                    exp_we;
        logic [4:0]              exp_addr;
        logic [7:0]              exp_data;
        logic [`INSTR_WIDTH-1:0] word;
        int                      cyc;
        seed        = 32'hb26f_5b0a;
        clk         = 1'b0;
        reset       = 1'b1;
        instruction = '0;
        model_sreg  = '0;
        model_pc    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = random_word();
        end
        repeat (5) @(posedge clk);
        #5;
        reset       = 1'b0;
        instruction = rom[pc];
        check_value("pc after reset", pc, 0);
        check_value("wb_en after reset", wb_en, 0);
        check_value("sreg after reset", sreg, 0);

        for (int n = 0; n < NUM_INSTR; n++) begin
            check_value("pc at fetch", pc, model_pc);
            word = rom[model_pc];
            step_model(word, exp_we, exp_addr, exp_data);
            cyc = 0;
            do begin
                next_cycle();
                cyc++;
            end while (!wb_en && cyc < (exp_we ? WB_TIMEOUT : 4));
            if (exp_we) begin
                if (!wb_en) begin
                    $display("Timed out waiting for wb_en after fetching word %h", word);
                    stop_with_failure();
                end
                check_value("cycles from fetch to wb_en", cyc, 3);
                check_value("wb_addr", wb_addr, exp_addr);
                check_value("wb_data", wb_data, exp_data);
                next_cycle();
                check_value("wb_en after writeback", wb_en, 0);   // Single-cycle pulse
            end else begin
                check_value("wb_en for a non-writing word", wb_en, 0);
            end
            check_value("sreg", sreg, model_sreg);
        end
        $display("Retired %0d instructions", NUM_INSTR);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* avr_core.f */
+incdir+hw
hw/avr_pkg.sv
hw/instr_decoder.sv
hw/alu_execute.sv
hw/result_unit.sv
hw/control_unit.sv
hw/avr_core.sv
tb/tb_avr_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_avr_core -f avr_core.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_avr_core > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
